// ==== flist.f ====
+incdir+logic
logic/super_counter_pkg.sv
logic/button_debouncer.sv
logic/count_message.sv
logic/uart_transmitter.sv
logic/uart_receiver.sv
logic/ack_parser.sv
logic/led_pulse.sv
logic/super_counter.sv
testbench/super_counter_tb.sv

// ==== Bender.yml ====
package:
  name: super_counter

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/super_counter_pkg.sv
      - logic/button_debouncer.sv
      - logic/count_message.sv
      - logic/uart_transmitter.sv
      - logic/uart_receiver.sv
      - logic/ack_parser.sv
      - logic/led_pulse.sv
      - logic/super_counter.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/super_counter_tb.sv

// ==== testbench/super_counter_tb.sv ====
// -------------------------------------
// Directed testbench for the serial event
// counter, with serial driver and monitor
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module super_counter_tb;

    localparam int BYTE_TIMEOUT = `SC_CLKS_PER_BIT * 20;
    localparam int RISE_TIMEOUT = `SC_CLKS_PER_BIT * 10 * (`SC_MSG_LEN + 2);
    localparam int HIGH_TIMEOUT = `SC_CYCLES_PER_MS * 5 + 100;

    logic clk;
    logic rst;
    logic btn_press;
    logic uart_rx;
    logic uart_tx;
    logic led;

    logic [7:0] rx_msg [`SC_MSG_LEN];
    int         rx_len;
    int         press_count;
    integer     seed;

    super_counter uut (
        .clk       (clk),
        .rst       (rst),
        .btn_press (btn_press),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .led       (led)
    );

    always #2 clk = ~clk;

    // -------------------------------------
    // Helpers
    // -------------------------------------

    // All driving and sampling happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input int expected,
                               input int actual, input int tol);
        int diff;
        diff = expected - actual;
        if (diff > tol || diff < -tol) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic press_button();
        btn_press = 1'b1;
        repeat (40) next_cycle();
        btn_press = 1'b0;
        repeat (40) next_cycle();
    endtask

    // 8N1 frame with the LSB first
    task automatic send_byte(input logic [7:0] data);
        uart_rx = 1'b0;
        repeat (`SC_CLKS_PER_BIT) next_cycle();
        for (int i = 0; i < 8; i++) begin
            uart_rx = data[i];
            repeat (`SC_CLKS_PER_BIT) next_cycle();
        end
        uart_rx = 1'b1;
        repeat (`SC_CLKS_PER_BIT) next_cycle();
    endtask

    task automatic send_line(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_byte(text[i]);
        end
        send_byte(`SC_ASCII_LF);
    endtask

    task automatic receive_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        while (uart_tx !== 1'b0) begin
            if (waited >= BYTE_TIMEOUT) begin
                abort_run("Timeout: no start bit seen on uart_tx");
            end
            next_cycle();
            waited++;
        end
        // Move to the middle of the start bit
        repeat (`SC_CLKS_PER_BIT / 2) next_cycle();
        if (uart_tx !== 1'b0) begin
            abort_run("Start bit on uart_tx ended before mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (`SC_CLKS_PER_BIT) next_cycle();
            data[i] = uart_tx;
        end
        repeat (`SC_CLKS_PER_BIT) next_cycle();
        if (uart_tx !== 1'b1) begin
            abort_run("Stop bit on uart_tx was not high");
        end
    endtask

    task automatic receive_message();
        logic [7:0] data;
        rx_len = 0;
        data = 8'h00;
        while (data != `SC_ASCII_LF) begin
            if (rx_len >= `SC_MSG_LEN) begin
                abort_run("Message on uart_tx ran past the longest length");
            end
            receive_byte(data);
            rx_msg[rx_len] = data;
            rx_len++;
        end
    endtask

    // Received text against the press count written in decimal
    task automatic check_message(input string test_name, input int count);
        string expected;
        expected = $sformatf("BTN %0d\n", count);
        check_value({test_name, " length"}, expected.len(), rx_len, 0);
        for (int i = 0; i < expected.len(); i++) begin
            check_value($sformatf("%s byte %0d", test_name, i), expected[i], rx_msg[i], 0);
        end
    endtask

    task automatic press_and_check(input string test_name);
        press_count++;
        fork
            press_button();
            receive_message();
        join
        check_message(test_name, press_count);
    endtask

    task automatic check_line_idle(input string test_name, input int cycles);
        repeat (cycles) begin
            check_value(test_name, 1, uart_tx, 0);
            next_cycle();
        end
    endtask

    task automatic measure_led_pulse(output int width);
        int waited;
        waited = 0;
        width = 0;
        while (led !== 1'b1) begin
            if (waited >= RISE_TIMEOUT) begin
                abort_run("Timeout: led never turned on");
            end
            next_cycle();
            waited++;
        end
        while (led === 1'b1) begin
            if (width >= HIGH_TIMEOUT) begin
                abort_run("Timeout: led never turned off");
            end
            width++;
            next_cycle();
        end
    endtask

    // -------------------------------------
    // Tests
    // -------------------------------------
    task automatic test_reset_state();
        repeat (200) begin
            check_value("reset_state uart_tx", 1, uart_tx, 0);
            check_value("reset_state led", 0, led, 0);
            next_cycle();
        end
    endtask

    task automatic test_first_press();
        press_and_check("first_press");
        check_line_idle("first_press idle", `SC_CLKS_PER_BIT * 3);
    endtask

    task automatic test_count_format();
        while (press_count < 10) begin
            press_and_check("count_format");
        end
    endtask

    // Second press lands while the formatter is still sending
    task automatic test_dropped_press();
        press_count++;
        fork
            press_button();
            receive_message();
            begin
                repeat (`SC_CLKS_PER_BIT * 20) next_cycle();
                press_button();
            end
        join
        check_message("dropped_press", press_count);
        check_line_idle("dropped_press idle", 3000);
        press_and_check("dropped_press next");
    endtask

    task automatic test_led_duration();
        int ms;
        int width;
        repeat (2) begin
            ms = 1 + ({$random(seed)} % 4);
            fork
                send_line($sformatf("ACK %0d", ms));
                measure_led_pulse(width);
            join
            check_value($sformatf("led_duration %0d ms", ms),
                        ms * `SC_CYCLES_PER_MS + 1, width, 2);
        end
    endtask

    task automatic test_malformed_command();
        int width;
        send_line("ACX 3");
        repeat (`SC_CYCLES_PER_MS * 5) begin
            check_value("malformed_command led", 0, led, 0);
            next_cycle();
        end
        fork
            send_line("ACK ");
            measure_led_pulse(width);
        join
        check_value("malformed_command empty value", 1, width, 0);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        btn_press   = 1'b0;
        uart_rx     = 1'b1;
        press_count = 0;
        seed        = 32'he8e4;
        repeat (10) next_cycle();
        rst = 1'b0;

        test_reset_state();
        test_first_press();
        test_count_format();
        test_dropped_press();
        test_led_duration();
        test_malformed_command();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/super_counter.sv ====
// -------------------------------------
// Serial event counter top level
// Button to UART out, UART in to LED
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none

module super_counter (
    input  logic clk,
    input  logic rst,
    input  logic btn_press,
    input  logic uart_rx,
    output logic uart_tx,
    output logic led
);

    logic                        pressed;
    logic                        tx_busy;
    super_counter_pkg::tx_req_t  tx_req;
    super_counter_pkg::rx_byte_t rx_byte;
    super_counter_pkg::led_cmd_t led_cmd;

    // -------------------------------------
    // Outgoing path
    // -------------------------------------
    button_debouncer button_debouncer_inst (
        .clk     (clk),
        .rst     (rst),
        .btn     (btn_press),
        .pressed (pressed)
    );

    count_message count_message_inst (
        .clk     (clk),
        .rst     (rst),
        .pressed (pressed),
        .tx_req  (tx_req),
        .tx_busy (tx_busy)
    );

    uart_transmitter uart_transmitter_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_req     (tx_req),
        .busy       (tx_busy),
        .serial_out (uart_tx)
    );

    // -------------------------------------
    // Incoming path
    // -------------------------------------
    uart_receiver uart_receiver_inst (
        .clk       (clk),
        .rst       (rst),
        .serial_in (uart_rx),
        .rx        (rx_byte)
    );

    ack_parser ack_parser_inst (
        .clk (clk),
        .rst (rst),
        .rx  (rx_byte),
        .cmd (led_cmd)
    );

    led_pulse led_pulse_inst (
        .clk (clk),
        .rst (rst),
        .cmd (led_cmd),
        .led (led)
    );

endmodule

`default_nettype wire

// ==== logic/led_pulse.sv ====
// -------------------------------------
// LED on-time counter
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none

module led_pulse (
    input  logic                        clk,
    input  logic                        rst,
    input  super_counter_pkg::led_cmd_t cmd,
    output logic                        led
);

    logic [31:0] remaining;

    // Trigger reloads, so led spans pulse_cycles plus one
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= 32'd0;
            led       <= 1'b0;
        end else if (cmd.trigger) begin
            remaining <= cmd.pulse_cycles;
            led       <= 1'b1;
        end else if (remaining != 32'd0) begin
            remaining <= remaining - 1'b1;
            led       <= 1'b1;
        end else begin
            led <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ack_parser.sv ====
// -------------------------------------
// "ACK d" line parser, ms to cycles
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module ack_parser (
    input  logic                        clk,
    input  logic                        rst,
    input  super_counter_pkg::rx_byte_t rx,
    output super_counter_pkg::led_cmd_t cmd
);

    super_counter_pkg::ack_state_e state;

    logic        in_number;
    logic        is_digit;
    logic        finish;
    logic [31:0] digit_val;
    logic [31:0] value_ms;
    logic [31:0] pulse_cycles;
    logic        trigger;

    assign in_number = (state == super_counter_pkg::ACK_GOT_SPACE)
                    || (state == super_counter_pkg::ACK_NUMBER);
    assign is_digit  = (rx.data >= `SC_ASCII_ZERO) && (rx.data <= `SC_ASCII_ZERO + 8'd9);
    assign digit_val = {24'd0, rx.data - `SC_ASCII_ZERO};
    assign finish    = rx.valid && in_number && (rx.data == `SC_ASCII_LF);

    // Value starts from zero at the space, so an empty number gives zero
    always_ff @(posedge clk) begin
        if (rx.valid && state == super_counter_pkg::ACK_GOT_K) begin
            value_ms <= '0;
        end else if (rx.valid && in_number && is_digit) begin
            value_ms <= value_ms * 10 + digit_val;
        end
        if (finish) begin
            pulse_cycles <= value_ms * `SC_CYCLES_PER_MS;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= super_counter_pkg::ACK_IDLE;
            trigger <= 1'b0;
        end else begin
            trigger <= finish;
            if (rx.valid) begin
                // Any unexpected byte drops back to idle
                state <= super_counter_pkg::ACK_IDLE;
                case (state)
                    super_counter_pkg::ACK_IDLE:
                        if (rx.data == "A") state <= super_counter_pkg::ACK_GOT_A;
                    super_counter_pkg::ACK_GOT_A:
                        if (rx.data == "C") state <= super_counter_pkg::ACK_GOT_C;
                    super_counter_pkg::ACK_GOT_C:
                        if (rx.data == "K") state <= super_counter_pkg::ACK_GOT_K;
                    super_counter_pkg::ACK_GOT_K:
                        if (rx.data == `SC_ASCII_SPACE) begin
                            state <= super_counter_pkg::ACK_GOT_SPACE;
                        end
                    default:
                        if (in_number && is_digit) state <= super_counter_pkg::ACK_NUMBER;
                endcase
            end
        end
    end

    assign cmd = '{trigger: trigger, pulse_cycles: pulse_cycles};

endmodule

`default_nettype wire

// ==== logic/uart_receiver.sv ====
// -------------------------------------
// UART receiver, mid-bit sampling
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module uart_receiver (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        serial_in,
    output super_counter_pkg::rx_byte_t rx
);

    localparam int unsigned CNT_W = $clog2(`SC_CLKS_PER_BIT);

    logic [2:0]       sync;
    logic             line;
    logic [CNT_W-1:0] bit_cnt;
    logic             tick;
    logic             busy;
    logic [3:0]       bit_idx;
    logic [7:0]       shifter;
    logic             rx_valid;

    // Three-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= 3'b111;
        end else begin
            sync <= {sync[1:0], serial_in};
        end
    end

    assign line = sync[2];

    // Half period on detection puts every later tick at mid-bit
    always_ff @(posedge clk) begin
        if (rst || !busy) begin
            bit_cnt <= CNT_W'(`SC_CLKS_PER_BIT / 2);
        end else if (tick) begin
            bit_cnt <= CNT_W'(`SC_CLKS_PER_BIT - 1);
        end else begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign tick = (bit_cnt == '0);

    // Tick 0 is the start bit, 1 to 8 are data, 9 lands in the stop bit
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            bit_idx  <= 4'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!line) begin
                    busy    <= 1'b1;
                    bit_idx <= 4'd0;
                end
            end else if (tick) begin
                bit_idx <= bit_idx + 1'b1;
                // A glitch is gone by mid start bit
                if (bit_idx == 4'd0 && line) begin
                    busy <= 1'b0;
                end
                if (bit_idx == 4'd9) begin
                    rx_valid <= 1'b1;
                    busy     <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && tick && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shifter <= {line, shifter[7:1]};
        end
    end

    assign rx = '{data: shifter, valid: rx_valid};

endmodule

`default_nettype wire

// ==== logic/uart_transmitter.sv ====
// -------------------------------------
// UART transmitter, 8N1 frames
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module uart_transmitter (
    input  logic                       clk,
    input  logic                       rst,
    input  super_counter_pkg::tx_req_t tx_req,
    output logic                       busy,
    output logic                       serial_out
);

    localparam int unsigned CNT_W = $clog2(`SC_CLKS_PER_BIT);

    logic [CNT_W-1:0] bit_cnt;
    logic             tick;
    logic [9:0]       shifter;
    logic [3:0]       bit_idx;

    // Bit period timer, held at full count while idle
    always_ff @(posedge clk) begin
        if (rst || !busy || tick) begin
            bit_cnt <= CNT_W'(`SC_CLKS_PER_BIT - 1);
        end else begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    assign tick = (bit_cnt == '0);

    // Frame is stop, data, start with the start bit at the LSB
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            shifter <= '1;
            bit_idx <= 4'd0;
        end else if (!busy) begin
            if (tx_req.start) begin
                busy    <= 1'b1;
                shifter <= {1'b1, tx_req.data, 1'b0};
                bit_idx <= 4'd0;
            end
        end else if (tick) begin
            shifter <= {1'b1, shifter[9:1]};
            bit_idx <= bit_idx + 1'b1;
            // End of stop bit
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
            end
        end
    end

    assign serial_out = shifter[0];

endmodule

`default_nettype wire

// ==== logic/count_message.sv ====
// -------------------------------------
// Decimal press counter and "BTN n"
// message sender
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module count_message (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pressed,
    output super_counter_pkg::tx_req_t tx_req,
    input  logic                       tx_busy
);

    super_counter_pkg::msg_state_e state;

    logic [3:0] digits      [`SC_BCD_DIGITS];
    logic [3:0] digits_next [`SC_BCD_DIGITS];
    logic       carry;
    logic [2:0] num_digits;

    super_counter_pkg::byte_t msg      [`SC_MSG_LEN];
    super_counter_pkg::byte_t msg_next [`SC_MSG_LEN];
    super_counter_pkg::byte_t tx_data;

    logic [3:0] idx;
    logic [3:0] last_idx;
    logic       waiting;
    logic       tx_start;
    logic       load_msg;
    logic       send_now;

    assign load_msg = (state == super_counter_pkg::MSG_IDLE) && pressed;
    assign send_now = (state == super_counter_pkg::MSG_SEND) && !tx_busy && !waiting;

    // BCD increment, ripple carry from the low digit, 99999 wraps to 0
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < `SC_BCD_DIGITS; i++) begin
            if (carry && digits[i] == 4'd9) begin
                digits_next[i] = 4'd0;
            end else begin
                digits_next[i] = digits[i] + {3'd0, carry};
                carry = 1'b0;
            end
        end
    end

    // Text of the next message, leading zeros suppressed
    always_comb begin
        num_digits = 3'd1;
        for (int i = 1; i < `SC_BCD_DIGITS; i++) begin
            if (digits_next[i] != 4'd0) begin
                num_digits = 3'(i + 1);
            end
        end
        msg_next[0] = "B";
        msg_next[1] = "T";
        msg_next[2] = "N";
        msg_next[3] = `SC_ASCII_SPACE;
        for (int k = 0; k < `SC_MSG_LEN - 4; k++) begin
            if (k < int'(num_digits)) begin
                msg_next[4+k] = `SC_ASCII_ZERO
                              + {4'd0, digits_next[int'(num_digits) - 1 - k]};
            end else begin
                msg_next[4+k] = `SC_ASCII_LF;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_msg) begin
            msg <= msg_next;
        end
        if (send_now) begin
            tx_data <= msg[idx];
        end
    end

    // -------------------------------------
    // Send FSM
    // -------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= super_counter_pkg::MSG_IDLE;
            digits   <= '{default: 4'd0};
            idx      <= 4'd0;
            last_idx <= 4'd0;
            waiting  <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= send_now;
            case (state)
                super_counter_pkg::MSG_IDLE: begin
                    if (pressed) begin
                        digits   <= digits_next;
                        last_idx <= 4'd4 + {1'b0, num_digits};
                        idx      <= 4'd0;
                        waiting  <= 1'b0;
                        state    <= super_counter_pkg::MSG_SEND;
                    end
                end
                super_counter_pkg::MSG_SEND: begin
                    if (send_now) begin
                        waiting <= 1'b1;
                    end else if (waiting && tx_busy) begin
                        // Transmitter took the byte
                        waiting <= 1'b0;
                        if (idx == last_idx) begin
                            state <= super_counter_pkg::MSG_IDLE;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= super_counter_pkg::MSG_IDLE;
            endcase
        end
    end

    assign tx_req = '{data: tx_data, start: tx_start};

endmodule

`default_nettype wire

// ==== logic/button_debouncer.sv ====
// -------------------------------------
// Button debouncer with synchronizer
// and single-cycle press pulse
// -------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "super_counter_macros.svh"

module button_debouncer (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic pressed
);

    logic                         sync_0;
    logic                         sync_1;
    logic [`SC_DEBOUNCE_BITS-1:0] count;
    logic                         stable;
    logic                         stable_q;

    // Two flops into the clock domain
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= btn;
            sync_1 <= sync_0;
        end
    end

    // New level is taken only once the counter saturates
    always_ff @(posedge clk) begin
        if (rst) begin
            count  <= '0;
            stable <= 1'b0;
        end else if (sync_1 != stable) begin
            if (count == '1) begin
                stable <= sync_1;
                count  <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end else begin
            count <= '0;
        end
    end

    // Rising edge of the filtered level
    always_ff @(posedge clk) begin
        if (rst) begin
            stable_q <= 1'b0;
            pressed  <= 1'b0;
        end else begin
            stable_q <= stable;
            pressed  <= stable && !stable_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/super_counter_pkg.sv ====
// -------------------------------------
// Character type, stage link structs
// and FSM state enums
// -------------------------------------
`default_nettype none

package super_counter_pkg;

    typedef logic [7:0] byte_t;

    // -------------------------------------
    // Links between pipeline stages
    // -------------------------------------

    // Formatter to transmitter, start is a single-cycle strobe
    typedef struct packed {
        byte_t data;
        logic  start;
    } tx_req_t;

    // Receiver to parser
    typedef struct packed {
        byte_t data;
        logic  valid;
    } rx_byte_t;

    // Parser to LED timer
    typedef struct packed {
        logic        trigger;
        logic [31:0] pulse_cycles;
    } led_cmd_t;

    // -------------------------------------
    // FSM states
    // -------------------------------------
    typedef enum logic {
        MSG_IDLE,
        MSG_SEND
    } msg_state_e;

    typedef enum logic [2:0] {
        ACK_IDLE,
        ACK_GOT_A,
        ACK_GOT_C,
        ACK_GOT_K,
        ACK_GOT_SPACE,
        ACK_NUMBER
    } ack_state_e;

endpackage

`default_nettype wire

// ==== logic/super_counter_macros.svh ====
// -------------------------------------
// Clock, serial line and debounce rates
// Message constants shared by the stages
// -------------------------------------
`ifndef SUPER_COUNTER_MACROS_SVH
`define SUPER_COUNTER_MACROS_SVH

// Clock and line rates
`define SC_CLOCK_HZ      12_000_000
`define SC_BAUD          115_200
`define SC_CLKS_PER_BIT  (`SC_CLOCK_HZ / `SC_BAUD)
`define SC_CYCLES_PER_MS (`SC_CLOCK_HZ / 1000)

// Button filter, level must hold for 2**bits cycles
`define SC_DEBOUNCE_BITS 4

// Message layout
`define SC_BCD_DIGITS    5
`define SC_MSG_LEN       10

// Characters used by both directions
`define SC_ASCII_ZERO    8'h30
`define SC_ASCII_SPACE   8'h20
`define SC_ASCII_LF      8'h0A

`endif
